// File: simple_ipod.f
ipod_pkg.sv
ipod_cmd_decode.sv
ipod_speed_ctrl.sv
ipod_flash_player.sv
ipod_sample_out.sv
ipod_top.sv
tb_flash_model.sv
tb_ipod.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_ipod
FILELIST  := simple_ipod.f
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_ipod.sv
`timescale 1ns/1ps

module tb_ipod;
  import ipod_pkg::*;

  localparam flash_addr_t song_last = 23'd15;
  localparam int div_dflt = int'(default_div);
  localparam int div_inc  = int'(div_step);
  localparam int div_lo   = int'(div_min);
  localparam int div_hi   = int'(div_max);
  localparam int cycle_limit = 60000;  // Five phases need roughly 40k cycles
  localparam int strobe_wait_limit = 3 * 4096;

  // Active-low digits 0 to F with segment g in bit 6
  localparam logic [6:0] seg_table [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  logic        CLK_50M = 1'b0;
  logic        rst;
  logic [7:0]  kbd_ascii;
  logic        kbd_valid;
  logic        speed_up;
  logic        speed_down;
  logic        speed_reset;
  logic        flash_read;
  flash_addr_t flash_addr;
  logic [3:0]  flash_byteenable;
  logic        flash_waitrequest;
  flash_word_t flash_readdata;
  logic        flash_readdatavalid;
  logic        playing;
  sample_t     sample;
  logic        sample_strobe;
  logic [6:0]  hex [6];

  // Reference model state
  logic        exp_playing;
  logic        exp_back;
  logic [3:0]  exp_word;   // 16-word song wraps in 4 bits
  logic        exp_half;
  logic [7:0]  exp_byte;
  int          exp_div;
  int          strobe_cnt;
  logic [1:0]  run_state;  // Second-half strobes seen since the last disturbance
  int          last_second;

  int          cycle = 0;
  int          outstanding;
  logic        accepted;
  logic        prev_wait;
  logic        prev_accept;
  flash_addr_t prev_addr;
  int          model_errs = 0;
  int          flash_errs = 0;
  int          seq_errs = 0;
  int          total_errs;
  int          strobes_before;

  always #10 CLK_50M = ~CLK_50M;

  ipod_top #(
    .last_word (song_last)
  ) i_dut (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .kbd_ascii           (kbd_ascii),
    .kbd_valid           (kbd_valid),
    .speed_up            (speed_up),
    .speed_down          (speed_down),
    .speed_reset         (speed_reset),
    .flash_read          (flash_read),
    .flash_addr          (flash_addr),
    .flash_byteenable    (flash_byteenable),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .playing             (playing),
    .sample              (sample),
    .sample_strobe       (sample_strobe),
    .hex0                (hex[0]),
    .hex1                (hex[1]),
    .hex2                (hex[2]),
    .hex3                (hex[3]),
    .hex4                (hex[4]),
    .hex5                (hex[5])
  );

  tb_flash_model i_flash (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .flash_read          (flash_read),
    .flash_addr          (flash_addr),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

  task automatic show_mismatch(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
  endtask

  // ==============================
  // Reference model of the player
  // ==============================
  always @(posedge CLK_50M)
  begin
    if (rst)
    begin
      exp_playing <= 1'b0;
      exp_back    <= 1'b0;
      exp_word    <= 4'd0;
      exp_half    <= 1'b0;
      exp_div     <= div_dflt;
      strobe_cnt  <= 0;
      run_state   <= 2'd0;
      last_second <= 0;
    end
    else
    begin
      if (sample_strobe)
      begin
        strobe_cnt <= strobe_cnt + 1;
        exp_byte = {2'b00, exp_word, 2'b00} + ((exp_half != exp_back) ? 8'd3 : 8'd1);
        assert (exp_playing)
        else
        begin
          model_errs++;
          $display("ERROR: sample_strobe at %0t while playback is stopped", $time);
        end
        assert (sample === exp_byte)
        else
        begin
          model_errs++;
          show_mismatch("sample", 32'(exp_byte), 32'(sample));
        end
        if (exp_half)
        begin
          exp_half <= 1'b0;
          exp_word <= exp_back ? exp_word - 4'd1 : exp_word + 4'd1;
          // Held halves come two ticks apart
          if (run_state == 2'd2)
            assert (cycle - last_second == 2 * exp_div)
            else
            begin
              model_errs++;
              show_mismatch("sample_strobe spacing", 2 * exp_div, cycle - last_second);
            end
          if (run_state != 2'd0)
            last_second <= cycle;
          if (run_state != 2'd2)
            run_state <= run_state + 2'd1;
        end
        else
          exp_half <= 1'b1;
      end

      if (kbd_valid)
      begin
        run_state <= 2'd0;
        case (kbd_ascii)
          "E", "e": exp_playing <= 1'b1;
          "D", "d": exp_playing <= 1'b0;
          "F", "f":
          begin
            if (exp_back)
              exp_half <= 1'b0;  // Held word dropped on a real change
            exp_back <= 1'b0;
          end
          "B", "b":
          begin
            if (!exp_back)
              exp_half <= 1'b0;
            exp_back <= 1'b1;
          end
          "R", "r":
          begin
            exp_word <= exp_back ? song_last[3:0] : 4'd0;
            exp_half <= 1'b0;
          end
          default: ;
        endcase
      end

      if (speed_reset)
        exp_div <= div_dflt;
      else if (speed_up)
        exp_div <= (exp_div - div_inc < div_lo) ? div_lo : exp_div - div_inc;
      else if (speed_down)
        exp_div <= (exp_div + div_inc > div_hi) ? div_hi : exp_div + div_inc;
      if (speed_reset || speed_up || speed_down)
        run_state <= 2'd0;  // Tick counter restarts
    end
  end

  // ==============================
  // Flash port protocol
  // ==============================
  assign accepted = flash_read && !flash_waitrequest;

  always @(posedge CLK_50M)
  begin
    if (rst)
    begin
      outstanding <= 0;
      prev_wait   <= 1'b0;
      prev_accept <= 1'b0;
      prev_addr   <= '0;
    end
    else
    begin
      assert (flash_byteenable === 4'hF)
      else
      begin
        flash_errs++;
        show_mismatch("flash_byteenable", 32'hF, 32'(flash_byteenable));
      end
      if (prev_wait)
        assert (flash_read === 1'b1 && flash_addr === prev_addr)
        else
        begin
          flash_errs++;
          $display("ERROR: flash request changed at %0t while waitrequest was high", $time);
        end
      if (prev_accept)
        assert (flash_read === 1'b0)
        else
        begin
          flash_errs++;
          $display("ERROR: flash_read still high at %0t after acceptance", $time);
        end
      if (accepted)
        assert (outstanding == 0)
        else
        begin
          flash_errs++;
          $display("ERROR: second flash read accepted at %0t", $time);
        end
      if (flash_readdatavalid)
        assert (outstanding == 1)
        else
        begin
          flash_errs++;
          $display("ERROR: flash data at %0t with no read outstanding", $time);
        end
      outstanding <= outstanding + int'(accepted) - int'(flash_readdatavalid);
      prev_wait   <= flash_read && flash_waitrequest;
      prev_accept <= accepted;
      prev_addr   <= flash_addr;
    end
  end

  always @(posedge CLK_50M)
  begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit)
    begin
      $display("ERROR: run stopped after %0d cycles, a test did not finish", cycle);
      $display("Verification failed");
      $finish;
    end
  end

  task automatic check_display();
    logic [3:0] nib;
    for (int i = 0; i < 6; i++)
    begin
      nib = exp_div[4*i +: 4];
      assert (hex[i] === seg_table[nib])
      else
      begin
        seq_errs++;
        show_mismatch($sformatf("hex%0d", i), 32'(seg_table[nib]), 32'(hex[i]));
      end
    end
  endtask

  task automatic send_key(input logic [7:0] code);
    @(posedge CLK_50M);
    kbd_ascii <= code;
    kbd_valid <= 1'b1;
    @(posedge CLK_50M);
    kbd_valid <= 1'b0;
    repeat (2) @(posedge CLK_50M);  // Decode, then player
    assert (playing === exp_playing)
    else
    begin
      seq_errs++;
      show_mismatch("playing", 32'(exp_playing), 32'(playing));
    end
  endtask

  // kind 0 is up, 1 is down, 2 is reset
  task automatic speed_pulse(input int kind);
    @(posedge CLK_50M);
    speed_up    <= (kind == 0);
    speed_down  <= (kind == 1);
    speed_reset <= (kind == 2);
    @(posedge CLK_50M);
    speed_up    <= 1'b0;
    speed_down  <= 1'b0;
    speed_reset <= 1'b0;
    repeat (2) @(posedge CLK_50M);
    check_display();
  endtask

  task automatic wait_strobes(input int count);
    int target;
    int waited;
    target = strobe_cnt + count;
    waited = 0;
    while (strobe_cnt < target && waited < count * strobe_wait_limit)
    begin
      @(posedge CLK_50M);
      waited++;
    end
    if (strobe_cnt < target)
    begin
      seq_errs++;
      $display("ERROR: only %0d of %0d samples arrived by %0t",
               count - (target - strobe_cnt), count, $time);
    end
  endtask

  task automatic sync_to_strobe();
    wait_strobes(1);
  endtask

  initial
  begin
    rst         = 1'b1;
    kbd_ascii   = 8'h00;
    kbd_valid   = 1'b0;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    repeat (4) @(posedge CLK_50M);
    rst <= 1'b0;

    // ==============================
    // Reset state
    // ==============================
    repeat (2) @(posedge CLK_50M);
    assert (playing === 1'b0 && sample_strobe === 1'b0 && flash_read === 1'b0)
    else
    begin
      seq_errs++;
      $display("ERROR: playing, sample_strobe or flash_read high after reset");
    end
    assert (sample === '0)
    else
    begin
      seq_errs++;
      show_mismatch("sample", 32'h0, 32'(sample));
    end
    check_display();

    // Forward play at the fastest rate
    send_key("E");
    repeat (30) speed_pulse(0);  // Two beyond the clamp
    wait_strobes(40);

    // Backward play wraps from word 0 to the last word
    sync_to_strobe();
    send_key("b");
    wait_strobes(32);

    // ==============================
    // Restart, stop, unknown keys
    // ==============================
    sync_to_strobe();
    send_key("R");
    wait_strobes(4);
    sync_to_strobe();
    send_key("f");
    sync_to_strobe();
    send_key("r");
    wait_strobes(4);
    sync_to_strobe();
    send_key("X");
    wait_strobes(4);
    sync_to_strobe();
    send_key("D");
    strobes_before = strobe_cnt;
    repeat (1000) @(posedge CLK_50M);
    send_key("x");
    assert (strobe_cnt == strobes_before)
    else
    begin
      seq_errs++;
      $display("ERROR: samples kept coming after stop");
    end

    // Divider limits, then play at the default rate
    repeat (125) speed_pulse(1);
    speed_pulse(2);
    repeat (2) speed_pulse(1);
    repeat (3) speed_pulse(0);
    speed_pulse(2);
    send_key("e");
    wait_strobes(12);
    sync_to_strobe();
    send_key("d");
    repeat (50) @(posedge CLK_50M);
    assert (outstanding == 0)
    else
    begin
      seq_errs++;
      $display("ERROR: a flash read never returned data");
    end

    total_errs = model_errs + flash_errs + seq_errs;
    $display("Summary: %0d errors (%0d sample, %0d flash, %0d sequence), %0d samples",
             total_errs, model_errs, flash_errs, seq_errs, strobe_cnt);
    if (total_errs == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// File: tb_flash_model.sv
`timescale 1ns/1ps

module tb_flash_model (
  input  logic                  CLK_50M,
  input  logic                  rst,
  input  logic                  flash_read,
  input  ipod_pkg::flash_addr_t flash_addr,
  output logic                  flash_waitrequest,
  output ipod_pkg::flash_word_t flash_readdata,
  output logic                  flash_readdatavalid
);
  import ipod_pkg::*;

  int          seed = 98395;
  logic [1:0]  wait_left;  // Wait states before the next request is taken
  logic [2:0]  lat_left;
  logic        busy;
  flash_addr_t addr_q;

  // Word a holds bytes 4a to 4a+3 with the lowest byte in bits 7:0
  function automatic flash_word_t word_at(input flash_addr_t a);
    logic [7:0] base;
    base    = {a[5:0], 2'b00} ^ a[13:6] ^ a[21:14] ^ {7'd0, a[22]};  // Upper bits fold in
    word_at = {base + 8'd3, base + 8'd2, base + 8'd1, base};
  endfunction

  assign flash_waitrequest = (wait_left != 2'd0);

  always @(posedge CLK_50M)
  begin
    if (rst)
    begin
      wait_left           <= 2'd1;
      lat_left            <= 3'd0;
      busy                <= 1'b0;
      addr_q              <= '0;
      flash_readdata      <= '0;
      flash_readdatavalid <= 1'b0;
    end
    else
    begin
      flash_readdatavalid <= 1'b0;
      if (flash_read && wait_left != 2'd0)
        wait_left <= wait_left - 2'd1;  // Still stalling
      else if (flash_read)
      begin
        wait_left <= 2'({$random(seed)} % 4);
        lat_left  <= 3'd1 + 3'({$random(seed)} % 4);
        addr_q    <= flash_addr;
        busy      <= 1'b1;
      end
      if (busy)
      begin
        if (lat_left == 3'd1)
        begin
          flash_readdata      <= word_at(addr_q);
          flash_readdatavalid <= 1'b1;
          busy                <= 1'b0;
        end
        else
          lat_left <= lat_left - 3'd1;
      end
    end
  end

endmodule

// File: ipod_top.sv
`timescale 1ns/1ps

module ipod_top #(
  parameter ipod_pkg::flash_addr_t last_word = ipod_pkg::last_word_default
) (
  input  logic                  CLK_50M,
  input  logic                  rst,
  input  logic [7:0]            kbd_ascii,
  input  logic                  kbd_valid,
  input  logic                  speed_up,
  input  logic                  speed_down,
  input  logic                  speed_reset,
  output logic                  flash_read,
  output ipod_pkg::flash_addr_t flash_addr,
  output logic [3:0]            flash_byteenable,
  input  logic                  flash_waitrequest,
  input  ipod_pkg::flash_word_t flash_readdata,
  input  logic                  flash_readdatavalid,
  output logic                  playing,
  output ipod_pkg::sample_t     sample,
  output logic                  sample_strobe,
  output logic [6:0]            hex0,
  output logic [6:0]            hex1,
  output logic [6:0]            hex2,
  output logic [6:0]            hex3,
  output logic [6:0]            hex4,
  output logic [6:0]            hex5
);
  import ipod_pkg::*;

  cmd_t    cmd;
  logic    cmd_valid;
  div_t    div;
  logic    sample_tick;
  sample_t sample_data;
  logic    sample_valid;

  // ==============================
  // Keyboard and speed front end
  // ==============================
  ipod_cmd_decode i_cmd_decode (
    .CLK_50M   (CLK_50M),
    .rst       (rst),
    .kbd_ascii (kbd_ascii),
    .kbd_valid (kbd_valid),
    .cmd       (cmd),
    .cmd_valid (cmd_valid)
  );

  ipod_speed_ctrl i_speed_ctrl (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .div         (div),
    .sample_tick (sample_tick)
  );

  // Player and flash port
  ipod_flash_player #(
    .last_word (last_word)
  ) i_flash_player (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .cmd                 (cmd),
    .cmd_valid           (cmd_valid),
    .sample_tick         (sample_tick),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_read          (flash_read),
    .flash_addr          (flash_addr),
    .flash_byteenable    (flash_byteenable),
    .playing             (playing),
    .sample_data         (sample_data),
    .sample_valid        (sample_valid)
  );

  ipod_sample_out i_sample_out (
    .CLK_50M       (CLK_50M),
    .rst           (rst),
    .sample_data   (sample_data),
    .sample_valid  (sample_valid),
    .div           (div),          // Shown on the hex digits
    .sample        (sample),
    .sample_strobe (sample_strobe),
    .hex0          (hex0),
    .hex1          (hex1),
    .hex2          (hex2),
    .hex3          (hex3),
    .hex4          (hex4),
    .hex5          (hex5)
  );

endmodule

// File: ipod_sample_out.sv
`timescale 1ns/1ps

module ipod_sample_out (
  input  logic              CLK_50M,
  input  logic              rst,
  input  ipod_pkg::sample_t sample_data,
  input  logic              sample_valid,
  input  ipod_pkg::div_t    div,
  output ipod_pkg::sample_t sample,
  output logic              sample_strobe,
  output logic [6:0]        hex0,
  output logic [6:0]        hex1,
  output logic [6:0]        hex2,
  output logic [6:0]        hex3,
  output logic [6:0]        hex4,
  output logic [6:0]        hex5
);
  import ipod_pkg::*;

  div_t        div_q;
  logic [23:0] disp_val;

  // Active-low segments, bit 6 is g
  function automatic logic [6:0] seg7(input logic [3:0] nib);
    case (nib)
      4'h0: seg7 = 7'h40;
      4'h1: seg7 = 7'h79;
      4'h2: seg7 = 7'h24;
      4'h3: seg7 = 7'h30;
      4'h4: seg7 = 7'h19;
      4'h5: seg7 = 7'h12;
      4'h6: seg7 = 7'h02;
      4'h7: seg7 = 7'h78;
      4'h8: seg7 = 7'h00;
      4'h9: seg7 = 7'h10;
      4'hA: seg7 = 7'h08;
      4'hB: seg7 = 7'h03;
      4'hC: seg7 = 7'h46;
      4'hD: seg7 = 7'h21;
      4'hE: seg7 = 7'h06;
      default: seg7 = 7'h0E;  // F
    endcase
  endfunction

  always_ff @(posedge CLK_50M)
  begin
    div_q <= div;
    if (rst)
    begin
      sample        <= '0;
      sample_strobe <= 1'b0;
    end
    else
    begin
      sample_strobe <= sample_valid;
      if (sample_valid)
        sample <= sample_data;
    end
  end

  assign disp_val = {8'h00, div_q};  // Upper two digits read 0

  assign hex0 = seg7(disp_val[3:0]);
  assign hex1 = seg7(disp_val[7:4]);
  assign hex2 = seg7(disp_val[11:8]);
  assign hex3 = seg7(disp_val[15:12]);
  assign hex4 = seg7(disp_val[19:16]);
  assign hex5 = seg7(disp_val[23:20]);

endmodule

// File: ipod_flash_player.sv
`timescale 1ns/1ps

module ipod_flash_player #(
  parameter ipod_pkg::flash_addr_t last_word = ipod_pkg::last_word_default
) (
  input  logic                  CLK_50M,
  input  logic                  rst,
  input  ipod_pkg::cmd_t        cmd,
  input  logic                  cmd_valid,
  input  logic                  sample_tick,
  input  logic                  flash_waitrequest,
  input  ipod_pkg::flash_word_t flash_readdata,
  input  logic                  flash_readdatavalid,
  output logic                  flash_read,
  output ipod_pkg::flash_addr_t flash_addr,
  output logic [3:0]            flash_byteenable,
  output logic                  playing,
  output ipod_pkg::sample_t     sample_data,
  output logic                  sample_valid
);
  import ipod_pkg::*;

  logic        backward;
  flash_addr_t addr;       // Word being played
  flash_addr_t addr_step;
  flash_word_t word_q;
  logic        half_ptr;   // Second half of word_q still to play
  logic        fetch_busy; // Read issued, data not back yet
  logic        drop_data;  // Outstanding read became stale
  logic        discard;

  assign flash_byteenable = 4'b1111;

  // Next word address, wrapping at both ends of the song
  always_comb
  begin
    if (backward)
      addr_step = (addr == '0) ? last_word : addr - 1'b1;
    else
      addr_step = (addr == last_word) ? '0 : addr + 1'b1;
  end

  // Restart or a real direction change invalidates the held word
  assign discard = cmd_valid && ((cmd == cmd_restart) ||
                                 (cmd == cmd_forward && backward) ||
                                 (cmd == cmd_backward && !backward));

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      playing      <= 1'b0;
      backward     <= 1'b0;
      addr         <= '0;
      flash_addr   <= '0;
      flash_read   <= 1'b0;
      half_ptr     <= 1'b0;
      fetch_busy   <= 1'b0;
      drop_data    <= 1'b0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= 1'b0;
      if (flash_read && !flash_waitrequest)
        flash_read <= 1'b0;  // Request accepted

      // ==============================
      // Tick: play held half or fetch
      // ==============================
      if (sample_tick && playing && !fetch_busy && !discard)
      begin
        if (half_ptr)
        begin
          sample_data  <= backward ? word_q[15:8] : word_q[31:24];
          sample_valid <= 1'b1;
          half_ptr     <= 1'b0;
          addr         <= addr_step;
        end
        else
        begin
          flash_read <= 1'b1;
          flash_addr <= addr;
          fetch_busy <= 1'b1;
        end
      end

      if (flash_readdatavalid && fetch_busy)
      begin
        fetch_busy <= 1'b0;
        drop_data  <= 1'b0;
        if (playing && !drop_data && !discard)
        begin
          word_q       <= flash_readdata;
          sample_data  <= backward ? flash_readdata[31:24] : flash_readdata[15:8];
          sample_valid <= 1'b1;
          half_ptr     <= 1'b1;
        end
      end

      // ==============================
      // Commands
      // ==============================
      if (cmd_valid)
      begin
        case (cmd)
          cmd_start:    playing  <= 1'b1;
          cmd_stop:     playing  <= 1'b0;
          cmd_forward:  backward <= 1'b0;
          cmd_backward: backward <= 1'b1;
          cmd_restart:  addr     <= backward ? last_word : '0;
          default:      playing  <= playing;
        endcase
      end
      if (discard)
      begin
        half_ptr <= 1'b0;
        if (fetch_busy && !flash_readdatavalid)
          drop_data <= 1'b1;
      end
    end
  end

endmodule

// File: ipod_speed_ctrl.sv
`timescale 1ns/1ps

module ipod_speed_ctrl (
  input  logic           CLK_50M,
  input  logic           rst,
  input  logic           speed_up,
  input  logic           speed_down,
  input  logic           speed_reset,
  output ipod_pkg::div_t div,
  output logic           sample_tick
);
  import ipod_pkg::*;

  div_t div_next;
  div_t tick_cnt;

  // ==============================
  // Divider step and clamp
  // ==============================
  always_comb
  begin
    div_next = div;
    if (speed_reset)
      div_next = default_div;
    else if (speed_up)  // Faster playback, smaller count
      div_next = (div < div_min + div_step) ? div_min : div - div_step;
    else if (speed_down)
      div_next = (div + div_step > div_max) ? div_max : div + div_step;
  end

  // ==============================
  // Sample tick
  // ==============================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      div         <= default_div;
      tick_cnt    <= default_div - 1'b1;
      sample_tick <= 1'b0;
    end
    else
    begin
      div         <= div_next;
      sample_tick <= 1'b0;
      if (div_next != div)
        tick_cnt <= div_next - 1'b1;  // New rate starts a fresh period
      else if (tick_cnt == '0)
      begin
        tick_cnt    <= div - 1'b1;
        sample_tick <= 1'b1;
      end
      else
        tick_cnt <= tick_cnt - 1'b1;
    end
  end

endmodule

// File: ipod_cmd_decode.sv
`timescale 1ns/1ps

module ipod_cmd_decode (
  input  logic           CLK_50M,
  input  logic           rst,
  input  logic [7:0]     kbd_ascii,
  input  logic           kbd_valid,
  output ipod_pkg::cmd_t cmd,
  output logic           cmd_valid
);
  import ipod_pkg::*;

  cmd_t match;

  // Upper and lower case map to the same command
  always_comb
  begin
    case (kbd_ascii)
      ascii_e, ascii_lc_e:
        match = cmd_start;
      ascii_d, ascii_lc_d:
        match = cmd_stop;
      ascii_f, ascii_lc_f:
        match = cmd_forward;
      ascii_b, ascii_lc_b:
        match = cmd_backward;
      ascii_r, ascii_lc_r:
        match = cmd_restart;
      default:
        match = cmd_none;  // Anything else is ignored
    endcase
  end

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      cmd       <= cmd_none;
      cmd_valid <= 1'b0;
    end
    else
    begin
      cmd_valid <= kbd_valid && (match != cmd_none);
      if (kbd_valid)
        cmd <= match;  // Hold last decoded code
    end
  end

endmodule

// File: ipod_pkg.sv
package ipod_pkg;

  // ==============================
  // Widths
  // ==============================
  localparam int sample_w = 8;
  localparam int word_w   = 32;
  localparam int addr_w   = 23;
  localparam int div_w    = 16;

  typedef logic signed [sample_w-1:0] sample_t;
  typedef logic [word_w-1:0]          flash_word_t;
  typedef logic [addr_w-1:0]          flash_addr_t;
  typedef logic [div_w-1:0]           div_t;

  typedef enum logic [2:0] {
    cmd_none,
    cmd_start,
    cmd_stop,
    cmd_forward,
    cmd_backward,
    cmd_restart
  } cmd_t;

  // ==============================
  // Divider limits
  // ==============================
  localparam div_t default_div = 16'd1136;  // 50 MHz / 44 kHz
  localparam div_t div_step    = 16'd32;
  localparam div_t div_min     = 16'd256;
  localparam div_t div_max     = 16'd4096;

  localparam flash_addr_t last_word_default = 23'h7FFFF;  // Last word of the song

  // Keyboard characters
  localparam logic [7:0] ascii_e    = 8'h45;
  localparam logic [7:0] ascii_d    = 8'h44;
  localparam logic [7:0] ascii_f    = 8'h46;
  localparam logic [7:0] ascii_b    = 8'h42;
  localparam logic [7:0] ascii_r    = 8'h52;
  localparam logic [7:0] ascii_lc_e = 8'h65;
  localparam logic [7:0] ascii_lc_d = 8'h64;
  localparam logic [7:0] ascii_lc_f = 8'h66;
  localparam logic [7:0] ascii_lc_b = 8'h62;
  localparam logic [7:0] ascii_lc_r = 8'h72;

endpackage
